// ==== logic/mx_pkg.sv ====
package mx_pkg;

  // ====================
  // Widths and sizes
  // ====================

  localparam int IN_MAN_WIDTH   = 8;
  localparam int IN_EXP_WIDTH   = 8;
  localparam int OUT_MAN_WIDTH  = 6;
  localparam int OUT_EXP_WIDTH  = 5;
  localparam int BLOCK_SIZE     = 4;
  localparam int LOG2_WIDTH     = $clog2(IN_MAN_WIDTH) + 1;

  // Block buffer covering the log2 pipeline plus slack
  localparam int FIFO_DEPTH     = 4;
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  // ====================
  // Exponent arithmetic
  // ====================

  localparam int EBIAS_IN       = 2 ** (IN_EXP_WIDTH - 1) - 1;
  localparam int EBIAS_OUT      = 2 ** (OUT_EXP_WIDTH - 1) - 1;

  // Signed widths that hold the unclamped exponent and the shift exactly
  localparam int FULL_EXP_WIDTH = IN_EXP_WIDTH + 2;
  localparam int SHIFT_WIDTH    = FULL_EXP_WIDTH + 1;
  localparam int WIDE_WIDTH     = IN_MAN_WIDTH + OUT_MAN_WIDTH;

  // Constant part of the output exponent
  localparam int EXP_OFFSET     = 2 - IN_MAN_WIDTH - EBIAS_IN + EBIAS_OUT;
  localparam int EXP_OUT_MAX    = 2 ** OUT_EXP_WIDTH - 1;
  localparam int SHIFT_BASE     = OUT_MAN_WIDTH - 2;

  // Symmetric saturation range
  localparam int MAX_MAN_OUT    = 2 ** (OUT_MAN_WIDTH - 1) - 1;
  localparam int MIN_MAN_OUT    = -MAX_MAN_OUT;

  // ====================
  // Types
  // ====================

  typedef logic signed [IN_MAN_WIDTH-1:0] in_man_t;
  typedef logic signed [OUT_MAN_WIDTH-1:0] out_man_t;
  typedef in_man_t [BLOCK_SIZE-1:0] in_man_array_t;
  typedef out_man_t [BLOCK_SIZE-1:0] out_man_array_t;

  typedef struct packed {
    in_man_array_t man;
    logic [IN_EXP_WIDTH-1:0] exp;
  } mx_in_block_t;

  typedef struct packed {
    out_man_array_t man;
    logic [OUT_EXP_WIDTH-1:0] exp;
  } mx_out_block_t;

  typedef enum logic {
    EMPTY = 1'b0,
    FULL  = 1'b1
  } stage_state_e;

endpackage

// ==== logic/log2_max_abs.sv ====
`timescale 1ns/10ps

module log2_max_abs (
  input  logic                          clk,
  input  logic                          reset,
  input  mx_pkg::in_man_array_t         mantissas,
  input  logic                          in_valid,
  output logic                          in_ready,
  output logic [mx_pkg::LOG2_WIDTH-1:0] log2_max,
  output logic                          out_valid,
  input  logic                          out_ready
);

  mx_pkg::stage_state_e s1_state;
  mx_pkg::stage_state_e s2_state;

  logic s1_ready;
  logic s2_ready;
  logic s1_load;
  logic s2_load;

  logic [mx_pkg::BLOCK_SIZE-1:0][mx_pkg::IN_MAN_WIDTH-1:0] abs_mag;
  logic [mx_pkg::BLOCK_SIZE-1:0][mx_pkg::IN_MAN_WIDTH-1:0] s1_mag;
  logic [mx_pkg::IN_MAN_WIDTH-1:0] mag_or;
  logic [mx_pkg::LOG2_WIDTH-1:0] s2_log2;

  // Index of the highest set bit plus one
  function automatic logic [mx_pkg::LOG2_WIDTH-1:0] bit_length(
    input logic [mx_pkg::IN_MAN_WIDTH-1:0] value
  );
    logic [mx_pkg::LOG2_WIDTH-1:0] len;
    len = '0;
    for (int i = 0; i < mx_pkg::IN_MAN_WIDTH; i++) begin
      if (value[i]) begin
        len = (mx_pkg::LOG2_WIDTH)'(i + 1);
      end
    end
    return len;
  endfunction

  // ====================
  // Stall control
  // ====================

  // A stage takes new data when empty or when its content moves on
  assign s2_ready  = (s2_state == mx_pkg::EMPTY) || out_ready;
  assign s1_ready  = (s1_state == mx_pkg::EMPTY) || s2_ready;
  assign s1_load   = in_valid && s1_ready;
  assign s2_load   = (s1_state == mx_pkg::FULL) && s2_ready;

  assign in_ready  = s1_ready;
  assign out_valid = (s2_state == mx_pkg::FULL);
  assign log2_max  = s2_log2;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_state <= mx_pkg::EMPTY;
      s2_state <= mx_pkg::EMPTY;
    end else begin
      if (s1_load) begin
        s1_state <= mx_pkg::FULL;
      end else if (s2_load) begin
        s1_state <= mx_pkg::EMPTY;
      end

      if (s2_load) begin
        s2_state <= mx_pkg::FULL;
      end else if (out_valid && out_ready) begin
        s2_state <= mx_pkg::EMPTY;
      end
    end
  end

  // ====================
  // Datapath
  // ====================

  // Magnitude of -2^(N-1) still fits N unsigned bits
  always_comb begin
    for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
      abs_mag[i] = mantissas[i][mx_pkg::IN_MAN_WIDTH-1] ? -mantissas[i] : mantissas[i];
    end
  end

  // OR of all magnitudes has the same top bit as the largest one
  always_comb begin
    mag_or = '0;
    for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
      mag_or = mag_or | s1_mag[i];
    end
  end

  always_ff @(posedge clk) begin
    if (s1_load) begin
      s1_mag <= abs_mag;
    end
    if (s2_load) begin
      s2_log2 <= bit_length(mag_or);
    end
  end

endmodule

// ==== logic/mx_block_fifo.sv ====
`timescale 1ns/10ps

module mx_block_fifo (
  input  logic                clk,
  input  logic                reset,
  input  mx_pkg::mx_in_block_t in_block,
  input  logic                in_valid,
  output logic                in_ready,
  output mx_pkg::mx_in_block_t out_block,
  output logic                out_valid,
  input  logic                out_ready
);

  mx_pkg::mx_in_block_t mem [mx_pkg::FIFO_DEPTH];

  logic [mx_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
  logic [mx_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
  logic [mx_pkg::FIFO_CNT_WIDTH-1:0] count;

  logic wr_en;
  logic rd_en;

  // ====================
  // Flags
  // ====================

  assign in_ready  = (count != (mx_pkg::FIFO_CNT_WIDTH)'(mx_pkg::FIFO_DEPTH));
  assign out_valid = (count != '0);

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  // Head comes straight from the storage flops
  assign out_block = mem[rd_ptr];

  // ====================
  // Pointers and count
  // ====================

  // Depth is a power of two, so the pointers wrap on their own
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({wr_en, rd_en})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_block;
    end
  end

endmodule

// ==== logic/mx_requantize.sv ====
`timescale 1ns/10ps

module mx_requantize (
  input  mx_pkg::mx_in_block_t          in_block,
  input  logic [mx_pkg::LOG2_WIDTH-1:0] log2_max,
  output mx_pkg::mx_out_block_t         out_block
);

  logic signed [mx_pkg::FULL_EXP_WIDTH-1:0] log2_ext;
  logic signed [mx_pkg::FULL_EXP_WIDTH-1:0] exp_in_ext;
  logic signed [mx_pkg::FULL_EXP_WIDTH-1:0] exp_full;
  logic [mx_pkg::OUT_EXP_WIDTH-1:0] exp_out;
  logic signed [mx_pkg::SHIFT_WIDTH-1:0] shift;

  // First matching rule wins for each element
  function automatic mx_pkg::out_man_t requant_man(
    input mx_pkg::in_man_t man,
    input logic signed [mx_pkg::SHIFT_WIDTH-1:0] sh
  );
    logic signed [mx_pkg::IN_MAN_WIDTH:0] man_s;
    logic [mx_pkg::IN_MAN_WIDTH:0] mag;
    logic signed [mx_pkg::SHIFT_WIDTH-1:0] lim_exp;
    logic [mx_pkg::WIDE_WIDTH-1:0] limit;
    logic signed [mx_pkg::WIDE_WIDTH-1:0] wide;
    logic [mx_pkg::SHIFT_WIDTH-1:0] rsh;
    mx_pkg::out_man_t sat;
    mx_pkg::out_man_t res;

    // One extra bit so that the magnitude of the most negative value is exact
    man_s = {man[mx_pkg::IN_MAN_WIDTH-1], man};
    mag   = (man_s < 0) ? -man_s : man_s;
    sat   = (man_s < 0) ? mx_pkg::out_man_t'(mx_pkg::MIN_MAN_OUT)
                        : mx_pkg::out_man_t'(mx_pkg::MAX_MAN_OUT);

    // Smallest magnitude that would overflow after the shift
    lim_exp = (mx_pkg::SHIFT_WIDTH)'(mx_pkg::OUT_MAN_WIDTH - 1) - sh;
    limit   = (mx_pkg::WIDE_WIDTH)'(1) << lim_exp;

    rsh  = -sh;
    wide = (mx_pkg::WIDE_WIDTH)'(man_s);

    if (man == '0) begin
      res = '0;
    end else if (sh >= mx_pkg::OUT_MAN_WIDTH) begin
      res = sat;
    end else if (sh <= -mx_pkg::IN_MAN_WIDTH) begin
      // Everything is shifted out and only the sign is left
      res = (man_s < 0) ? mx_pkg::out_man_t'(-1) : '0;
    end else if ((mx_pkg::WIDE_WIDTH)'(mag) >= limit) begin
      res = sat;
    end else if (sh >= 0) begin
      wide = wide <<< sh;
      res  = wide[mx_pkg::OUT_MAN_WIDTH-1:0];
    end else begin
      // Truncates toward minus infinity
      wide = wide >>> rsh;
      res  = wide[mx_pkg::OUT_MAN_WIDTH-1:0];
    end
    return res;
  endfunction

  // ====================
  // Output exponent
  // ====================

  assign log2_ext   = (mx_pkg::FULL_EXP_WIDTH)'(log2_max);
  assign exp_in_ext = (mx_pkg::FULL_EXP_WIDTH)'(in_block.exp);
  assign exp_full   = log2_ext + exp_in_ext + (mx_pkg::FULL_EXP_WIDTH)'(mx_pkg::EXP_OFFSET);

  always_comb begin
    if (log2_max == '0) begin
      exp_out = '0;
    end else if (exp_full > mx_pkg::EXP_OUT_MAX) begin
      exp_out = '1;
    end else if (exp_full < 0) begin
      exp_out = '0;
    end else begin
      exp_out = exp_full[mx_pkg::OUT_EXP_WIDTH-1:0];
    end
  end

  // ====================
  // Shift amount
  // ====================

  // Clamping error is folded back into the mantissa shift
  assign shift = (mx_pkg::SHIFT_WIDTH)'(exp_full)
               - (mx_pkg::SHIFT_WIDTH)'(exp_out)
               - (mx_pkg::SHIFT_WIDTH)'(log2_max)
               + (mx_pkg::SHIFT_WIDTH)'(mx_pkg::SHIFT_BASE);

  // Per-element mantissas
  always_comb begin
    out_block.exp = exp_out;
    for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
      out_block.man[i] = requant_man(in_block.man[i], shift);
    end
  end

endmodule

// ==== logic/mxint_cast.sv ====
`timescale 1ns/10ps

module mxint_cast (
  input  logic                  clk,
  input  logic                  reset,
  input  mx_pkg::mx_in_block_t  in_block,
  input  logic                  in_valid,
  output logic                  in_ready,
  output mx_pkg::mx_out_block_t out_block,
  output logic                  out_valid,
  input  logic                  out_ready
);

  // Fork branches
  logic log2_in_valid;
  logic log2_in_ready;
  logic fifo_in_valid;
  logic fifo_in_ready;

  // Join branches
  logic [mx_pkg::LOG2_WIDTH-1:0] log2_max;
  logic log2_valid;
  logic log2_ready;

  mx_pkg::mx_in_block_t head_block;
  logic head_valid;
  logic head_ready;

  // ====================
  // Input fork
  // ====================

  // Both branches take the block in the same cycle, or neither does
  assign in_ready      = log2_in_ready && fifo_in_ready;
  assign log2_in_valid = in_valid && fifo_in_ready;
  assign fifo_in_valid = in_valid && log2_in_ready;

  log2_max_abs log2_max_abs_i (
    .clk       (clk),
    .reset     (reset),
    .mantissas (in_block.man),
    .in_valid  (log2_in_valid),
    .in_ready  (log2_in_ready),
    .log2_max  (log2_max),
    .out_valid (log2_valid),
    .out_ready (log2_ready)
  );

  // Holds the block while its log2 is worked out
  mx_block_fifo mx_block_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .in_block  (in_block),
    .in_valid  (fifo_in_valid),
    .in_ready  (fifo_in_ready),
    .out_block (head_block),
    .out_valid (head_valid),
    .out_ready (head_ready)
  );

  // ====================
  // Join
  // ====================

  // Both paths are in order, so heads always belong together
  assign out_valid  = head_valid && log2_valid;
  assign log2_ready = out_ready && head_valid;
  assign head_ready = out_ready && log2_valid;

  mx_requantize mx_requantize_i (
    .in_block  (head_block),
    .log2_max  (log2_max),
    .out_block (out_block)
  );

endmodule

// ==== tests/mxint_model.svh ====
`ifndef MXINT_MODEL_SVH
`define MXINT_MODEL_SVH

// Bits needed to hold a non-negative value
function automatic int bit_length_of(input int value);
  int len;
  int v;
  len = 0;
  v = value;
  while (v > 0) begin
    len++;
    v = v / 2;
  end
  return len;
endfunction

// Bit length of the largest mantissa magnitude in the block
function automatic int largest_bit_length(input mx_pkg::mx_in_block_t blk);
  int max_mag;
  int mag;
  max_mag = 0;
  for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
    mag = $signed(blk.man[i]);
    if (mag < 0) begin
      mag = -mag;
    end
    if (mag > max_mag) begin
      max_mag = mag;
    end
  end
  return bit_length_of(max_mag);
endfunction

// First rule that applies wins for one mantissa
function automatic int scaled_mantissa(input int m, input int shift);
  int sat;
  int mag;
  int res;
  sat = (m < 0) ? mx_pkg::MIN_MAN_OUT : mx_pkg::MAX_MAN_OUT;
  mag = (m < 0) ? -m : m;
  if (m == 0) begin
    res = 0;
  end else if (shift >= mx_pkg::OUT_MAN_WIDTH) begin
    res = sat;
  end else if (-shift >= mx_pkg::IN_MAN_WIDTH) begin
    res = (m < 0) ? -1 : 0;
  end else if (mag >= (1 << (mx_pkg::OUT_MAN_WIDTH - shift - 1))) begin
    res = sat;
  end else if (shift >= 0) begin
    res = m << shift;
  end else begin
    res = m >>> (-shift);
  end
  return res;
endfunction

// Expected output block for one input block
function automatic mx_pkg::mx_out_block_t expected_block(input mx_pkg::mx_in_block_t blk);
  mx_pkg::mx_out_block_t res;
  int log2_max;
  int full_exp;
  int out_exp;
  int exp_top;
  int shift;
  log2_max = largest_bit_length(blk);
  exp_top  = (1 << mx_pkg::OUT_EXP_WIDTH) - 1;
  full_exp = log2_max - mx_pkg::IN_MAN_WIDTH + 2 + int'(blk.exp)
           - mx_pkg::EBIAS_IN + mx_pkg::EBIAS_OUT;
  if (log2_max == 0) begin
    out_exp = 0;
  end else if (full_exp > exp_top) begin
    out_exp = exp_top;
  end else if (full_exp < 0) begin
    out_exp = 0;
  end else begin
    out_exp = full_exp;
  end
  shift = (full_exp - out_exp) + mx_pkg::OUT_MAN_WIDTH - log2_max - 2;
  res.exp = (mx_pkg::OUT_EXP_WIDTH)'(out_exp);
  for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
    res.man[i] = mx_pkg::out_man_t'(scaled_mantissa($signed(blk.man[i]), shift));
  end
  return res;
endfunction

`endif

// ==== tests/mxint_cast_tb.sv ====
`timescale 1ns/10ps

module mxint_cast_tb;

  localparam int WAIT_LIMIT    = 200;
  localparam int RANDOM_BLOCKS = 400;
  localparam int STALL_BLOCKS  = 200;
  localparam int STREAM_BLOCKS = 20;

  logic clk = 1'b0;
  logic reset;
  mx_pkg::mx_in_block_t in_block;
  logic in_valid;
  logic in_ready;
  mx_pkg::mx_out_block_t out_block;
  logic out_valid;
  logic out_ready;

  integer seed;
  // 0 ready always, 1 random ready, 2 ready held low
  int ready_mode;
  logic next_ready;

  // Scoreboard
  mx_pkg::mx_out_block_t expected_q[$];
  int cycle;
  int sent_count;
  int acc_count;
  int out_count;
  int mark_acc;
  int mark_out;
  int first_acc_cycle;
  int first_out_cycle;
  int last_out_cycle;

  `include "mxint_model.svh"

  mxint_cast mxint_cast_i (
    .clk       (clk),
    .reset     (reset),
    .in_block  (in_block),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_block (out_block),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #50 clk = ~clk;

  // ====================
  // Checks
  // ====================

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic compare_flag(input logic actual, input logic expected, input string name);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic compare_count(input int actual, input int expected, input string name);
    if (actual != expected) begin
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic compare_out_block(input mx_pkg::mx_out_block_t expected,
                                   input mx_pkg::mx_out_block_t actual);
    if (actual.exp !== expected.exp) begin
      $display("FAILED at %0t: out_block.exp expected %0d, got %0d",
               $time, expected.exp, actual.exp);
      stop_with_failure();
    end
    for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
      if (actual.man[i] !== expected.man[i]) begin
        $display("FAILED at %0t: out_block.man[%0d] expected %0d, got %0d",
                 $time, i, expected.man[i], actual.man[i]);
        stop_with_failure();
      end
    end
  endtask

  // Sampled at the falling edge where every handshake signal has settled
  always @(negedge clk) begin
    if (!reset) begin
      cycle++;
      if (in_valid && in_ready) begin
        expected_q.push_back(expected_block(in_block));
        if (acc_count == mark_acc) begin
          first_acc_cycle = cycle;
        end
        acc_count++;
      end
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          $display("An output block came out with no input block waiting for it");
          stop_with_failure();
        end else begin
          compare_out_block(expected_q.pop_front(), out_block);
          if (out_count == mark_out) begin
            first_out_cycle = cycle;
          end
          last_out_cycle = cycle;
          out_count++;
        end
      end
    end
  end

  // ====================
  // Stimulus
  // ====================

  // Mode is taken at the edge and the new ready level goes out 1 ns later
  always @(posedge clk) begin
    case (ready_mode)
      0: next_ready = 1'b1;
      1: next_ready = ({$random(seed)} % 10) >= 4;
      default: next_ready = 1'b0;
    endcase
    #1;
    out_ready = next_ready;
  end

  function automatic mx_pkg::mx_in_block_t make_block(input int m3, input int m2,
                                                      input int m1, input int m0,
                                                      input int exp);
    mx_pkg::mx_in_block_t blk;
    blk.man[3] = mx_pkg::in_man_t'(m3);
    blk.man[2] = mx_pkg::in_man_t'(m2);
    blk.man[1] = mx_pkg::in_man_t'(m1);
    blk.man[0] = mx_pkg::in_man_t'(m0);
    blk.exp    = (mx_pkg::IN_EXP_WIDTH)'(exp);
    return blk;
  endfunction

  // Edge exponents, fully random ones and a band around the useful range
  function automatic mx_pkg::mx_in_block_t random_block();
    mx_pkg::mx_in_block_t blk;
    int sel;
    int width;
    sel = {$random(seed)} % 8;
    case (sel)
      0: blk.exp = '0;
      1: blk.exp = '1;
      2, 3: blk.exp = (mx_pkg::IN_EXP_WIDTH)'($random(seed));
      default: blk.exp = (mx_pkg::IN_EXP_WIDTH)'(107 + {$random(seed)} % 41);
    endcase
    width = 1 + {$random(seed)} % mx_pkg::IN_MAN_WIDTH;
    for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
      if ({$random(seed)} % 8 == 0) begin
        blk.man[i] = '0;
      end else begin
        blk.man[i] = mx_pkg::in_man_t'($random(seed)) >>> (mx_pkg::IN_MAN_WIDTH - width);
      end
    end
    return blk;
  endfunction

  // Called 1 ns after a rising edge and returns 1 ns after the accepting edge
  task automatic send_block(input mx_pkg::mx_in_block_t blk);
    int waited;
    in_block = blk;
    in_valid = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out waiting for the DUT to accept an input block");
        stop_with_failure();
      end
      @(negedge clk);
    end
    @(posedge clk);
    sent_count++;
    #1;
  endtask

  task automatic idle_cycle();
    in_valid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic drain_outputs();
    int waited;
    in_valid = 1'b0;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out with %0d expected blocks still missing", expected_q.size());
        stop_with_failure();
      end
    end
    @(posedge clk);
    #1;
    compare_count(out_count, sent_count, "output block count");
  endtask

  task automatic send_directed();
    // All zeros
    send_block(make_block(0, 0, 0, 0, 130));
    // Top clamp with saturation by sign
    send_block(make_block(1, 2, 3, 4, 255));
    send_block(make_block(-1, -5, -100, -2, 255));
    send_block(make_block(64, -3, 1, 0, 150));
    // Clamp at zero with a full flush
    send_block(make_block(-3, 5, -128, 7, 0));
    // Normal right shifts
    send_block(make_block(100, -77, 3, -1, 127));
    send_block(make_block(-128, 127, 0, 64, 127));
    // Normal left shift
    send_block(make_block(1, -2, 0, 1, 120));
  endtask

  initial begin
    seed = 32'h272c;
    ready_mode = 0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_block = '0;
    out_ready = 1'b1;
    cycle = 0;
    sent_count = 0;
    acc_count = 0;
    out_count = 0;
    mark_acc = -1;
    mark_out = -1;
    first_acc_cycle = 0;
    first_out_cycle = 0;
    last_out_cycle = 0;

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // State straight after reset
    @(negedge clk);
    compare_flag(out_valid, 1'b0, "out_valid");
    compare_flag(in_ready, 1'b1, "in_ready");
    @(posedge clk);
    #1;

    for (int n = 0; n < RANDOM_BLOCKS; n++) begin
      if ({$random(seed)} % 5 == 0) begin
        idle_cycle();
      end
      send_block(random_block());
    end
    drain_outputs();

    send_directed();
    drain_outputs();

    // ====================
    // Back-pressure
    // ====================

    ready_mode = 1;
    for (int n = 0; n < STALL_BLOCKS / 2; n++) begin
      send_block(random_block());
    end
    fork
      begin
        for (int n = 0; n < STALL_BLOCKS / 2; n++) begin
          send_block(random_block());
        end
      end
      begin
        ready_mode = 2;
        repeat (16) @(posedge clk);
        #1;
        ready_mode = 1;
      end
    join
    ready_mode = 0;
    drain_outputs();

    // Streaming with no gaps
    mark_acc = acc_count;
    mark_out = out_count;
    for (int n = 0; n < STREAM_BLOCKS; n++) begin
      send_block(random_block());
    end
    drain_outputs();
    compare_count(first_out_cycle - first_acc_cycle, 2, "first output latency");
    compare_count(last_out_cycle - first_out_cycle + 1, STREAM_BLOCKS, "steady state outputs");

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+tests
logic/mx_pkg.sv
logic/log2_max_abs.sv
logic/mx_block_fifo.sv
logic/mx_requantize.sv
logic/mxint_cast.sv
tests/mxint_cast_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sources.f \
  --top-module mxint_cast_tb -o mxint_cast_sim

status=0
./obj_dir/mxint_cast_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  exit "$status"
fi
grep -q "SIMULATION PASSED" sim.log
